/* Makefile */
# Verilator build for the exu pipeline testbench

VERILATOR ?= verilator
TOP       ?= tb_exu
FLIST     ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= All tests passed

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(shell grep -v '^+' $(FLIST)) tb_exu_checks.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* build.f */
exu_pkg.sv
exu_operand_stage.sv
exu_alu.sv
exu_branch.sv
exu_execute_stage.sv
exu_writeback_stage.sv
exu_top.sv
+incdir+.
tb_exu.sv

/* exu_alu.sv */
// exu alu, integer and multiply operations with word-mode result extension
`timescale 1ns/10ps
`default_nettype none

module exu_alu (
  input  wire logic [exu_pkg::xlen-1:0] i_src_a,
  input  wire logic [exu_pkg::xlen-1:0] i_src_b,
  input  wire logic [exu_pkg::xlen-1:0] i_imm,
  input  exu_pkg::alu_ctr_t             i_alu_ctr,
  input  wire logic                     i_word_cut,
  output logic [exu_pkg::xlen-1:0]      o_result,
  output logic                          o_zero,
  output logic                          o_less
);

  logic [exu_pkg::xlen-1:0]   diff;
  logic                       less_s;
  logic                       less_u;
  logic [5:0]                 shamt;
  logic [exu_pkg::xlen-1:0]   sra_src;
  logic [exu_pkg::xlen-1:0]   sra_res;
  logic [2*exu_pkg::xlen-1:0] prod_ss;
  logic [2*exu_pkg::xlen-1:0] prod_su;
  logic [2*exu_pkg::xlen-1:0] prod_uu;
  logic [exu_pkg::xlen-1:0]   raw;

  assign diff   = i_src_a - i_src_b;
  assign less_s = $signed(i_src_a) < $signed(i_src_b);
  assign less_u = i_src_a < i_src_b;

  assign o_zero = (diff == '0);
  assign o_less = (i_alu_ctr == exu_pkg::alu_sltu) ? less_u : less_s;

  // word shifts only use 5 bits of the amount
  assign shamt = i_word_cut ? {1'b0, i_src_b[4:0]} : i_src_b[5:0];

  // sraw shifts the low word as a signed value
  assign sra_src = i_word_cut ? {{32{i_src_a[31]}}, i_src_a[31:0]} : i_src_a;
  assign sra_res = $signed(sra_src) >>> shamt;

  // full width products, the low half is the same for all three
  assign prod_ss = {{exu_pkg::xlen{i_src_a[exu_pkg::xlen-1]}}, i_src_a} *
                   {{exu_pkg::xlen{i_src_b[exu_pkg::xlen-1]}}, i_src_b};
  assign prod_su = {{exu_pkg::xlen{i_src_a[exu_pkg::xlen-1]}}, i_src_a} *
                   {{exu_pkg::xlen{1'b0}}, i_src_b};
  assign prod_uu = {{exu_pkg::xlen{1'b0}}, i_src_a} *
                   {{exu_pkg::xlen{1'b0}}, i_src_b};

  always_comb begin
    case (i_alu_ctr)
      exu_pkg::alu_copy_imm: raw = i_imm;
      exu_pkg::alu_add:      raw = i_src_a + i_src_b;
      exu_pkg::alu_sub:      raw = diff;
      exu_pkg::alu_slt:      raw = {{(exu_pkg::xlen-1){1'b0}}, less_s};
      exu_pkg::alu_sltu:     raw = {{(exu_pkg::xlen-1){1'b0}}, less_u};
      exu_pkg::alu_xor:      raw = i_src_a ^ i_src_b;
      exu_pkg::alu_and:      raw = i_src_a & i_src_b;
      exu_pkg::alu_or:       raw = i_src_a | i_src_b;
      exu_pkg::alu_sll:      raw = i_src_a << shamt;
      exu_pkg::alu_srl:      raw = i_src_a >> shamt;
      exu_pkg::alu_sra:      raw = sra_res;
      exu_pkg::alu_mul:      raw = prod_uu[exu_pkg::xlen-1:0];
      exu_pkg::alu_mulh:     raw = prod_ss[2*exu_pkg::xlen-1:exu_pkg::xlen];
      exu_pkg::alu_mulhsu:   raw = prod_su[2*exu_pkg::xlen-1:exu_pkg::xlen];
      exu_pkg::alu_mulhu:    raw = prod_uu[2*exu_pkg::xlen-1:exu_pkg::xlen];
      // divide and remainder codes land here
      default:               raw = '0;
    endcase
  end

  // word results are sign extended from bit 31
  assign o_result = i_word_cut ? {{32{raw[31]}}, raw[31:0]} : raw;

endmodule

`default_nettype wire

/* exu_branch.sv */
// exu branch unit, picks the next pc from the branch kind and alu flags
`timescale 1ns/10ps
`default_nettype none

module exu_branch (
  input  exu_pkg::branch_t              i_branch,
  input  wire logic                     i_zero,
  input  wire logic                     i_less,
  input  wire logic [exu_pkg::xlen-1:0] i_pc,
  input  wire logic [exu_pkg::xlen-1:0] i_rs1,
  input  wire logic [exu_pkg::xlen-1:0] i_imm,
  output logic [exu_pkg::xlen-1:0]      o_next_pc
);

  logic use_imm;
  logic use_rs1;

  always_comb begin
    use_rs1 = 1'b0;
    case (i_branch)
      exu_pkg::br_jal:  use_imm = 1'b1;
      exu_pkg::br_jalr: begin
        use_imm = 1'b1;
        use_rs1 = 1'b1;
      end
      exu_pkg::br_beq:  use_imm = i_zero;
      exu_pkg::br_bne:  use_imm = ~i_zero;
      exu_pkg::br_blt:  use_imm = i_less;
      exu_pkg::br_bge:  use_imm = ~i_less;
      default:          use_imm = 1'b0;
    endcase
  end

  // not taken falls through to pc+4
  assign o_next_pc = (use_rs1 ? i_rs1 : i_pc) + (use_imm ? i_imm : exu_pkg::xlen'(4));

endmodule

`default_nettype wire

/* exu_execute_stage.sv */
// exu execute stage, runs the alu and branch unit and registers their results
`timescale 1ns/10ps
`default_nettype none

module exu_execute_stage (
  input  wire logic                     i_clk,
  input  wire logic                     i_reset,
  input  wire logic                     i_valid,
  input  wire logic [exu_pkg::xlen-1:0] i_src_a,
  input  wire logic [exu_pkg::xlen-1:0] i_src_b,
  input  wire logic [exu_pkg::xlen-1:0] i_rs1,
  input  wire logic [exu_pkg::xlen-1:0] i_rs2,
  input  wire logic [exu_pkg::xlen-1:0] i_imm,
  input  wire logic [exu_pkg::xlen-1:0] i_pc,
  input  exu_pkg::alu_ctr_t             i_alu_ctr,
  input  wire logic                     i_word_cut,
  input  exu_pkg::branch_t              i_branch,
  input  exu_pkg::memop_t               i_memop,
  input  wire logic                     i_mem_to_reg,
  input  wire logic                     i_sel_csr,
  input  exu_pkg::exctr_t               i_exctr,
  input  wire logic [exu_pkg::xlen-1:0] i_rdata,
  input  wire logic                     i_invalid,
  output logic                          o_valid,
  output logic [exu_pkg::xlen-1:0]      o_alu_result,
  output logic [exu_pkg::xlen-1:0]      o_next_pc,
  output logic [exu_pkg::xlen-1:0]      o_src_a,
  output logic [exu_pkg::xlen-1:0]      o_rs2,
  output exu_pkg::memop_t               o_memop,
  output logic                          o_mem_to_reg,
  output logic                          o_sel_csr,
  output exu_pkg::exctr_t               o_exctr,
  output logic [exu_pkg::xlen-1:0]      o_rdata,
  output logic                          o_invalid
);

  logic [exu_pkg::xlen-1:0] alu_result;
  logic [exu_pkg::xlen-1:0] next_pc;
  logic                     zero;
  logic                     less;

  exu_alu u_alu (
    .i_src_a    (i_src_a),
    .i_src_b    (i_src_b),
    .i_imm      (i_imm),
    .i_alu_ctr  (i_alu_ctr),
    .i_word_cut (i_word_cut),
    .o_result   (alu_result),
    .o_zero     (zero),
    .o_less     (less)
  );

  exu_branch u_branch (
    .i_branch  (i_branch),
    .i_zero    (zero),
    .i_less    (less),
    .i_pc      (i_pc),
    .i_rs1     (i_rs1),
    .i_imm     (i_imm),
    .o_next_pc (next_pc)
  );

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_valid <= 1'b0;
    end else begin
      o_valid <= i_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    o_alu_result <= alu_result;
    o_next_pc    <= next_pc;
    o_src_a      <= i_src_a;
    o_rs2        <= i_rs2;
    o_memop      <= i_memop;
    o_mem_to_reg <= i_mem_to_reg;
    o_sel_csr    <= i_sel_csr;
    o_exctr      <= i_exctr;
    o_rdata      <= i_rdata;
    o_invalid    <= i_invalid;
  end

endmodule

`default_nettype wire

/* exu_operand_stage.sv */
// exu operand stage, registers the instruction and forms the word-cut alu operands
`timescale 1ns/10ps
`default_nettype none

module exu_operand_stage (
  input  wire logic                     i_clk,
  input  wire logic                     i_reset,
  input  wire logic                     i_valid,
  input  wire logic [exu_pkg::xlen-1:0] i_rs1,
  input  wire logic [exu_pkg::xlen-1:0] i_rs2,
  input  wire logic [exu_pkg::xlen-1:0] i_imm,
  input  wire logic [exu_pkg::xlen-1:0] i_pc,
  input  wire logic                     i_alua_src,
  input  exu_pkg::alub_sel_t            i_alub_src,
  input  exu_pkg::alu_ctr_t             i_alu_ctr,
  input  wire logic                     i_word_cut,
  input  exu_pkg::branch_t              i_branch,
  input  exu_pkg::memop_t               i_memop,
  input  wire logic                     i_mem_to_reg,
  input  wire logic                     i_sel_csr,
  input  exu_pkg::exctr_t               i_exctr,
  input  wire logic [exu_pkg::xlen-1:0] i_rdata,
  input  wire logic                     i_is_invalid_inst,
  output logic                          o_valid,
  output logic [exu_pkg::xlen-1:0]      o_src_a,
  output logic [exu_pkg::xlen-1:0]      o_src_b,
  output logic [exu_pkg::xlen-1:0]      o_rs1,
  output logic [exu_pkg::xlen-1:0]      o_rs2,
  output logic [exu_pkg::xlen-1:0]      o_imm,
  output logic [exu_pkg::xlen-1:0]      o_pc,
  output exu_pkg::alu_ctr_t             o_alu_ctr,
  output logic                          o_word_cut,
  output exu_pkg::branch_t              o_branch,
  output exu_pkg::memop_t               o_memop,
  output logic                          o_mem_to_reg,
  output logic                          o_sel_csr,
  output exu_pkg::exctr_t               o_exctr,
  output logic [exu_pkg::xlen-1:0]      o_rdata,
  output logic                          o_invalid
);

  logic [exu_pkg::xlen-1:0] rs1_cut;
  logic [exu_pkg::xlen-1:0] rs2_cut;
  logic [exu_pkg::xlen-1:0] imm_cut;
  logic [exu_pkg::xlen-1:0] src_b;

  // word ops see only the low half, zero extended
  assign rs1_cut = i_word_cut ? {32'b0, i_rs1[31:0]} : i_rs1;
  assign rs2_cut = i_word_cut ? {32'b0, i_rs2[31:0]} : i_rs2;
  assign imm_cut = i_word_cut ? {32'b0, i_imm[31:0]} : i_imm;

  always_comb begin
    case (i_alub_src)
      exu_pkg::alub_rs2:  src_b = rs2_cut;
      exu_pkg::alub_imm:  src_b = imm_cut;
      exu_pkg::alub_four: src_b = exu_pkg::xlen'(4);
      default:            src_b = '0;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_valid <= 1'b0;
    end else begin
      o_valid <= i_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    o_src_a      <= i_alua_src ? i_pc : rs1_cut;
    o_src_b      <= src_b;
    o_rs1        <= i_rs1;
    o_rs2        <= i_rs2;
    o_imm        <= i_imm;
    o_pc         <= i_pc;
    o_alu_ctr    <= i_alu_ctr;
    o_word_cut   <= i_word_cut;
    o_branch     <= i_branch;
    o_memop      <= i_memop;
    o_mem_to_reg <= i_mem_to_reg;
    o_sel_csr    <= i_sel_csr;
    o_exctr      <= i_exctr;
    o_rdata      <= i_rdata;
    o_invalid    <= i_is_invalid_inst;
  end

endmodule

`default_nettype wire

/* exu_pkg.sv */
// exu package with data width, control codes and latency of the execute pipeline
`default_nettype none

package exu_pkg;

  localparam int xlen = 64;

  // cycles from i_valid to o_valid
  localparam int exu_latency = 3;

  typedef enum logic [4:0] {
    alu_add      = 5'b00000,
    alu_sub      = 5'b00001,
    alu_slt      = 5'b00010,
    alu_sltu     = 5'b00011,
    alu_xor      = 5'b00100,
    alu_and      = 5'b00101,
    alu_or       = 5'b00110,
    alu_sll      = 5'b00111,
    alu_srl      = 5'b01000,
    alu_sra      = 5'b01001,
    alu_mul      = 5'b01010,
    alu_copy_imm = 5'b01111,
    alu_mulh     = 5'b11001,
    alu_mulhsu   = 5'b11010,
    alu_mulhu    = 5'b11011
  } alu_ctr_t;

  typedef enum logic [2:0] {
    br_none = 3'b000,
    br_jal  = 3'b001,
    br_jalr = 3'b010,
    br_beq  = 3'b100,
    br_bne  = 3'b101,
    br_blt  = 3'b110,
    br_bge  = 3'b111
  } branch_t;

  typedef enum logic [2:0] {
    mem_lb  = 3'b000,
    mem_lbu = 3'b001,
    mem_lh  = 3'b010,
    mem_lhu = 3'b011,
    mem_lw  = 3'b100,
    mem_lwu = 3'b101,
    mem_ld  = 3'b110
  } memop_t;

  typedef enum logic [1:0] {
    alub_rs2  = 2'b00,
    alub_imm  = 2'b01,
    alub_four = 2'b10
  } alub_sel_t;

  // only two codes have a meaning here, the rest are ignored
  typedef logic [3:0] exctr_t;
  localparam exctr_t exctr_csr_write = 4'b0000;
  localparam exctr_t exctr_ebreak    = 4'b1110;

endpackage

`default_nettype wire

/* exu_top.sv */
// exu top, three-stage execute pipeline of operand, execute and writeback
`timescale 1ns/10ps
`default_nettype none

module exu_top (
  input  wire logic                     i_clk,
  input  wire logic                     i_reset,
  input  wire logic                     i_valid,
  input  wire logic [exu_pkg::xlen-1:0] i_rs1,
  input  wire logic [exu_pkg::xlen-1:0] i_rs2,
  input  wire logic [exu_pkg::xlen-1:0] i_imm,
  input  wire logic [exu_pkg::xlen-1:0] i_pc,
  input  wire logic                     i_alua_src,
  input  exu_pkg::alub_sel_t            i_alub_src,
  input  exu_pkg::alu_ctr_t             i_alu_ctr,
  input  wire logic                     i_word_cut,
  input  exu_pkg::branch_t              i_branch,
  input  exu_pkg::memop_t               i_memop,
  input  wire logic                     i_mem_to_reg,
  input  wire logic                     i_sel_csr,
  input  exu_pkg::exctr_t               i_exctr,
  input  wire logic [exu_pkg::xlen-1:0] i_rdata,
  input  wire logic                     i_is_invalid_inst,
  output logic                          o_valid,
  output logic [exu_pkg::xlen-1:0]      o_alu_result,
  output logic [exu_pkg::xlen-1:0]      o_next_pc,
  output logic [exu_pkg::xlen-1:0]      o_gpr_wdata,
  output logic [exu_pkg::xlen-1:0]      o_csr_wdata,
  output logic                          o_ebreak,
  output logic                          o_invalid
);

  // operand to execute
  logic                     op_valid;
  logic [exu_pkg::xlen-1:0] op_src_a;
  logic [exu_pkg::xlen-1:0] op_src_b;
  logic [exu_pkg::xlen-1:0] op_rs1;
  logic [exu_pkg::xlen-1:0] op_rs2;
  logic [exu_pkg::xlen-1:0] op_imm;
  logic [exu_pkg::xlen-1:0] op_pc;
  exu_pkg::alu_ctr_t        op_alu_ctr;
  logic                     op_word_cut;
  exu_pkg::branch_t         op_branch;
  exu_pkg::memop_t          op_memop;
  logic                     op_mem_to_reg;
  logic                     op_sel_csr;
  exu_pkg::exctr_t          op_exctr;
  logic [exu_pkg::xlen-1:0] op_rdata;
  logic                     op_invalid;

  // execute to writeback
  logic                     ex_valid;
  logic [exu_pkg::xlen-1:0] ex_alu_result;
  logic [exu_pkg::xlen-1:0] ex_next_pc;
  logic [exu_pkg::xlen-1:0] ex_src_a;
  logic [exu_pkg::xlen-1:0] ex_rs2;
  exu_pkg::memop_t          ex_memop;
  logic                     ex_mem_to_reg;
  logic                     ex_sel_csr;
  exu_pkg::exctr_t          ex_exctr;
  logic [exu_pkg::xlen-1:0] ex_rdata;
  logic                     ex_invalid;

  exu_operand_stage u_operand (
    .i_clk             (i_clk),
    .i_reset           (i_reset),
    .i_valid           (i_valid),
    .i_rs1             (i_rs1),
    .i_rs2             (i_rs2),
    .i_imm             (i_imm),
    .i_pc              (i_pc),
    .i_alua_src        (i_alua_src),
    .i_alub_src        (i_alub_src),
    .i_alu_ctr         (i_alu_ctr),
    .i_word_cut        (i_word_cut),
    .i_branch          (i_branch),
    .i_memop           (i_memop),
    .i_mem_to_reg      (i_mem_to_reg),
    .i_sel_csr         (i_sel_csr),
    .i_exctr           (i_exctr),
    .i_rdata           (i_rdata),
    .i_is_invalid_inst (i_is_invalid_inst),
    .o_valid           (op_valid),
    .o_src_a           (op_src_a),
    .o_src_b           (op_src_b),
    .o_rs1             (op_rs1),
    .o_rs2             (op_rs2),
    .o_imm             (op_imm),
    .o_pc              (op_pc),
    .o_alu_ctr         (op_alu_ctr),
    .o_word_cut        (op_word_cut),
    .o_branch          (op_branch),
    .o_memop           (op_memop),
    .o_mem_to_reg      (op_mem_to_reg),
    .o_sel_csr         (op_sel_csr),
    .o_exctr           (op_exctr),
    .o_rdata           (op_rdata),
    .o_invalid         (op_invalid)
  );

  exu_execute_stage u_execute (
    .i_clk        (i_clk),
    .i_reset      (i_reset),
    .i_valid      (op_valid),
    .i_src_a      (op_src_a),
    .i_src_b      (op_src_b),
    .i_rs1        (op_rs1),
    .i_rs2        (op_rs2),
    .i_imm        (op_imm),
    .i_pc         (op_pc),
    .i_alu_ctr    (op_alu_ctr),
    .i_word_cut   (op_word_cut),
    .i_branch     (op_branch),
    .i_memop      (op_memop),
    .i_mem_to_reg (op_mem_to_reg),
    .i_sel_csr    (op_sel_csr),
    .i_exctr      (op_exctr),
    .i_rdata      (op_rdata),
    .i_invalid    (op_invalid),
    .o_valid      (ex_valid),
    .o_alu_result (ex_alu_result),
    .o_next_pc    (ex_next_pc),
    .o_src_a      (ex_src_a),
    .o_rs2        (ex_rs2),
    .o_memop      (ex_memop),
    .o_mem_to_reg (ex_mem_to_reg),
    .o_sel_csr    (ex_sel_csr),
    .o_exctr      (ex_exctr),
    .o_rdata      (ex_rdata),
    .o_invalid    (ex_invalid)
  );

  exu_writeback_stage u_writeback (
    .i_clk        (i_clk),
    .i_reset      (i_reset),
    .i_valid      (ex_valid),
    .i_alu_result (ex_alu_result),
    .i_next_pc    (ex_next_pc),
    .i_src_a      (ex_src_a),
    .i_rs2        (ex_rs2),
    .i_memop      (ex_memop),
    .i_mem_to_reg (ex_mem_to_reg),
    .i_sel_csr    (ex_sel_csr),
    .i_exctr      (ex_exctr),
    .i_rdata      (ex_rdata),
    .i_invalid    (ex_invalid),
    .o_valid      (o_valid),
    .o_alu_result (o_alu_result),
    .o_next_pc    (o_next_pc),
    .o_gpr_wdata  (o_gpr_wdata),
    .o_csr_wdata  (o_csr_wdata),
    .o_ebreak     (o_ebreak),
    .o_invalid    (o_invalid)
  );

endmodule

`default_nettype wire

/* exu_writeback_stage.sv */
// exu writeback stage, load extension, gpr and csr write values, ebreak and invalid pulses
`timescale 1ns/10ps
`default_nettype none

module exu_writeback_stage (
  input  wire logic                     i_clk,
  input  wire logic                     i_reset,
  input  wire logic                     i_valid,
  input  wire logic [exu_pkg::xlen-1:0] i_alu_result,
  input  wire logic [exu_pkg::xlen-1:0] i_next_pc,
  input  wire logic [exu_pkg::xlen-1:0] i_src_a,
  input  wire logic [exu_pkg::xlen-1:0] i_rs2,
  input  exu_pkg::memop_t               i_memop,
  input  wire logic                     i_mem_to_reg,
  input  wire logic                     i_sel_csr,
  input  exu_pkg::exctr_t               i_exctr,
  input  wire logic [exu_pkg::xlen-1:0] i_rdata,
  input  wire logic                     i_invalid,
  output logic                          o_valid,
  output logic [exu_pkg::xlen-1:0]      o_alu_result,
  output logic [exu_pkg::xlen-1:0]      o_next_pc,
  output logic [exu_pkg::xlen-1:0]      o_gpr_wdata,
  output logic [exu_pkg::xlen-1:0]      o_csr_wdata,
  output logic                          o_ebreak,
  output logic                          o_invalid
);

  logic [exu_pkg::xlen-1:0] load_data;
  logic [exu_pkg::xlen-1:0] gpr_wdata;

  always_comb begin
    case (i_memop)
      exu_pkg::mem_lb:  load_data = {{56{i_rdata[7]}}, i_rdata[7:0]};
      exu_pkg::mem_lbu: load_data = {56'b0, i_rdata[7:0]};
      exu_pkg::mem_lh:  load_data = {{48{i_rdata[15]}}, i_rdata[15:0]};
      exu_pkg::mem_lhu: load_data = {48'b0, i_rdata[15:0]};
      exu_pkg::mem_lw:  load_data = {{32{i_rdata[31]}}, i_rdata[31:0]};
      exu_pkg::mem_lwu: load_data = {32'b0, i_rdata[31:0]};
      exu_pkg::mem_ld:  load_data = i_rdata;
      default:          load_data = '0;
    endcase
  end

  // csr reads come in on rs2
  assign gpr_wdata = i_mem_to_reg ? load_data : (i_sel_csr ? i_rs2 : i_alu_result);

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_valid   <= 1'b0;
      o_ebreak  <= 1'b0;
      o_invalid <= 1'b0;
    end else begin
      o_valid   <= i_valid;
      o_ebreak  <= i_valid && (i_exctr == exu_pkg::exctr_ebreak);
      o_invalid <= i_valid && i_invalid;
    end
  end

  always_ff @(posedge i_clk) begin
    o_alu_result <= i_alu_result;
    o_next_pc    <= i_next_pc;
    o_gpr_wdata  <= gpr_wdata;
    o_csr_wdata  <= (i_exctr == exu_pkg::exctr_csr_write) ? i_src_a : '0;
  end

endmodule

`default_nettype wire

/* tb_exu_checks.svh */
// exu testbench helpers, expected-value model and compare tasks
`ifndef TB_EXU_CHECKS_SVH
`define TB_EXU_CHECKS_SVH

function automatic logic [63:0] low_word(logic [63:0] v, logic wc);
  return wc ? {32'h0, v[31:0]} : v;
endfunction

function automatic logic [63:0] model_src_a(row_t r);
  return r.asrc ? r.pc : low_word(r.rs1, r.wc);
endfunction

function automatic logic [63:0] model_src_b(row_t r);
  if (r.bsel == exu_pkg::alub_imm) return low_word(r.imm, r.wc);
  if (r.bsel == exu_pkg::alub_four) return 64'd4;
  return low_word(r.rs2, r.wc);
endfunction

function automatic logic [63:0] model_alu(row_t r);
  logic [63:0] a;
  logic [63:0] b;
  logic [63:0] res;
  int sh;
  logic signed [63:0] sa64;
  logic signed [127:0] s128a;
  logic signed [127:0] s128b;
  logic [127:0] u128a;
  logic [127:0] u128b;
  logic [127:0] prod;
  a = model_src_a(r);
  b = model_src_b(r);
  sh = r.wc ? int'(b % 32) : int'(b % 64);
  u128a = {64'h0, a};
  u128b = {64'h0, b};
  s128a = 128'($signed(a));
  s128b = 128'($signed(b));
  case (r.ctr)
    exu_pkg::alu_copy_imm: res = r.imm;
    exu_pkg::alu_add:  res = a + b;
    exu_pkg::alu_sub:  res = a - b;
    exu_pkg::alu_slt:  res = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
    exu_pkg::alu_sltu: res = (a < b) ? 64'd1 : 64'd0;
    exu_pkg::alu_xor:  res = a ^ b;
    exu_pkg::alu_and:  res = a & b;
    exu_pkg::alu_or:   res = a | b;
    exu_pkg::alu_sll:  res = a << sh;
    exu_pkg::alu_srl:  res = a >> sh;
    exu_pkg::alu_sra: begin
      sa64 = r.wc ? $signed({{32{a[31]}}, a[31:0]}) : $signed(a);
      res = sa64 >>> sh;
    end
    exu_pkg::alu_mul: res = a * b;
    exu_pkg::alu_mulh: begin
      prod = s128a * s128b;
      res = prod[127:64];
    end
    exu_pkg::alu_mulhsu: begin
      prod = s128a * $signed(u128b);
      res = prod[127:64];
    end
    exu_pkg::alu_mulhu: begin
      prod = u128a * u128b;
      res = prod[127:64];
    end
    default: res = 64'h0;
  endcase
  return r.wc ? {{32{res[31]}}, res[31:0]} : res;
endfunction

function automatic logic [63:0] model_next_pc(row_t r);
  logic [63:0] a;
  logic [63:0] b;
  logic lt;
  logic taken;
  a = model_src_a(r);
  b = model_src_b(r);
  lt = (r.ctr == exu_pkg::alu_sltu) ? (a < b) : ($signed(a) < $signed(b));
  case (r.br)
    exu_pkg::br_jal:  return r.pc + r.imm;
    exu_pkg::br_jalr: return r.rs1 + r.imm;
    exu_pkg::br_beq:  taken = (a == b);
    exu_pkg::br_bne:  taken = (a != b);
    exu_pkg::br_blt:  taken = lt;
    exu_pkg::br_bge:  taken = !lt;
    default:          taken = 1'b0;
  endcase
  return taken ? r.pc + r.imm : r.pc + 64'd4;
endfunction

function automatic logic [63:0] model_gpr(row_t r, logic [63:0] alu);
  logic [63:0] d;
  d = r.rdata;
  if (r.m2r) begin
    case (r.mop)
      exu_pkg::mem_lb:  return 64'($signed(d[7:0]));
      exu_pkg::mem_lbu: return 64'(d[7:0]);
      exu_pkg::mem_lh:  return 64'($signed(d[15:0]));
      exu_pkg::mem_lhu: return 64'(d[15:0]);
      exu_pkg::mem_lw:  return 64'($signed(d[31:0]));
      exu_pkg::mem_lwu: return 64'(d[31:0]);
      default:          return d;
    endcase
  end
  return r.csel ? r.rs2 : alu;
endfunction

task automatic check_word(string what, string label,
                          logic [exu_pkg::xlen-1:0] got, logic [exu_pkg::xlen-1:0] exp);
  if (got !== exp) begin
    $display("CHECK FAILED at %0t: %s %s got %h expected %h", $time, label, what, got, exp);
    stop_failed();
  end
endtask

task automatic check_bit(string what, string label, logic got, logic exp);
  if (got !== exp) begin
    $display("CHECK FAILED at %0t: %s %s got %b expected %b", $time, label, what, got, exp);
    stop_failed();
  end
endtask

`endif

/* tb_exu.sv */
// exu testbench, table-driven stimulus with an expected-value queue
`timescale 1ns/10ps
`default_nettype none

module tb_exu;

  typedef struct packed {
    exu_pkg::alu_ctr_t  ctr;
    logic               wc;
    logic               asrc;
    exu_pkg::alub_sel_t bsel;
    exu_pkg::branch_t   br;
    exu_pkg::memop_t    mop;
    logic               m2r;
    logic               csel;
    exu_pkg::exctr_t    ex;
    logic               inv;
    logic [63:0]        rs1;
    logic [63:0]        rs2;
    logic [63:0]        imm;
    logic [63:0]        pc;
    logic [63:0]        rdata;
  } row_t;

  typedef struct packed {
    logic [63:0] alu;
    logic [63:0] npc;
    logic [63:0] gpr;
    logic [63:0] csr;
    logic        eb;
    logic        inv;
    int          idx;
    int          entry;
  } expect_t;

  localparam int period = 4;
  localparam exu_pkg::exctr_t ex_nop = 4'b0001;
  localparam logic [63:0] sign_bit = 64'h8000_0000_0000_0000;
  localparam logic [63:0] ones = '1;

  logic i_clk;
  logic i_reset;
  logic i_valid;
  logic [63:0] i_rs1;
  logic [63:0] i_rs2;
  logic [63:0] i_imm;
  logic [63:0] i_pc;
  logic i_alua_src;
  exu_pkg::alub_sel_t i_alub_src;
  exu_pkg::alu_ctr_t i_alu_ctr;
  logic i_word_cut;
  exu_pkg::branch_t i_branch;
  exu_pkg::memop_t i_memop;
  logic i_mem_to_reg;
  logic i_sel_csr;
  exu_pkg::exctr_t i_exctr;
  logic [63:0] i_rdata;
  logic i_is_invalid_inst;
  logic o_valid;
  logic [63:0] o_alu_result;
  logic [63:0] o_next_pc;
  logic [63:0] o_gpr_wdata;
  logic [63:0] o_csr_wdata;
  logic o_ebreak;
  logic o_invalid;

  row_t rows[$];
  string labels[$];
  expect_t pending[$];
  int cycle = 0;
  int checked = 0;
  logic table_ready = 1'b0;

  exu_top DUT (.*);

  task automatic stop_failed();
    $display("Some tests failed");
    $fatal(1);
  endtask

  `include "tb_exu_checks.svh"

  function automatic logic [63:0] rand64();
    return {$urandom, $urandom};
  endfunction

  // rnd replaces rs1 and rs2 with random values
  task automatic add_row(string label, exu_pkg::alu_ctr_t ctr, logic wc, logic asrc,
                         exu_pkg::alub_sel_t bsel, exu_pkg::branch_t br, logic rnd,
                         logic [63:0] rs1, logic [63:0] rs2, logic [63:0] imm);
    row_t r;
    r = '0;
    r.ctr = ctr;
    r.wc = wc;
    r.asrc = asrc;
    r.bsel = bsel;
    r.br = br;
    r.mop = exu_pkg::mem_ld;
    r.ex = ex_nop;
    r.rs1 = rnd ? rand64() : rs1;
    r.rs2 = rnd ? rand64() : rs2;
    r.imm = imm;
    r.pc = 64'h8000_1000 + 64'(rows.size() * 4);
    r.rdata = rand64();
    rows.push_back(r);
    labels.push_back(label);
  endtask

  // writeback fields of the row added last
  task automatic set_wb(exu_pkg::memop_t mop, logic m2r, logic csel,
                        exu_pkg::exctr_t ex, logic inv);
    rows[rows.size()-1].mop = mop;
    rows[rows.size()-1].m2r = m2r;
    rows[rows.size()-1].csel = csel;
    rows[rows.size()-1].ex = ex;
    rows[rows.size()-1].inv = inv;
  endtask

  task automatic load_table();
    add_row("add", exu_pkg::alu_add, 0, 0, exu_pkg::alub_rs2, exu_pkg::br_none, 1, 0, 0, 0);
    add_row("sub", exu_pkg::alu_sub, 0, 0, exu_pkg::alub_rs2, exu_pkg::br_none, 1, 0, 0, 0);
    add_row("slt", exu_pkg::alu_slt, 0, 0, exu_pkg::alub_rs2, exu_pkg::br_none, 0,
            sign_bit, 1, 0);
    add_row("sltu", exu_pkg::alu_sltu, 0, 0, exu_pkg::alub_rs2, exu_pkg::br_none, 0,
            sign_bit, 1, 0);
    add_row("xor", exu_pkg::alu_xor, 0, 0, exu_pkg::alub_rs2, exu_pkg::br_none, 1, 0, 0, 0);
    add_row("and", exu_pkg::alu_and, 0, 0, exu_pkg::alub_rs2, exu_pkg::br_none, 1, 0, 0, 0);
    add_row("or", exu_pkg::alu_or, 0, 0, exu_pkg::alub_rs2, exu_pkg::br_none, 0, 0, ones, 0);
    add_row("sll", exu_pkg::alu_sll, 0, 0, exu_pkg::alub_rs2, exu_pkg::br_none, 1, 0, 0, 0);
    add_row("srl", exu_pkg::alu_srl, 0, 0, exu_pkg::alub_rs2, exu_pkg::br_none, 1, 0, 0, 0);
    add_row("sra", exu_pkg::alu_sra, 0, 0, exu_pkg::alub_rs2, exu_pkg::br_none, 0,
            sign_bit | 64'hf0, 4, 0);
    add_row("copy_imm", exu_pkg::alu_copy_imm, 0, 0, exu_pkg::alub_imm, exu_pkg::br_none, 1,
            0, 0, 64'hffff_f123_4000_0000);
    add_row("mul", exu_pkg::alu_mul, 0, 0, exu_pkg::alub_rs2, exu_pkg::br_none, 1, 0, 0, 0);
    add_row("mulh", exu_pkg::alu_mulh, 0, 0, exu_pkg::alub_rs2, exu_pkg::br_none, 0,
            sign_bit, sign_bit, 0);
    add_row("mulhsu", exu_pkg::alu_mulhsu, 0, 0, exu_pkg::alub_rs2, exu_pkg::br_none, 0,
            ones, ones, 0);
    add_row("mulhu", exu_pkg::alu_mulhu, 0, 0, exu_pkg::alub_rs2, exu_pkg::br_none, 1, 0, 0, 0);
    add_row("addw", exu_pkg::alu_add, 1, 0, exu_pkg::alub_rs2, exu_pkg::br_none, 0,
            64'hdead_0000_7fff_ffff, 1, 0);
    add_row("subw", exu_pkg::alu_sub, 1, 0, exu_pkg::alub_rs2, exu_pkg::br_none, 0, 0, ones, 0);
    add_row("sraw", exu_pkg::alu_sra, 1, 0, exu_pkg::alub_rs2, exu_pkg::br_none, 0,
            64'h8000_0000, 64'h24, 0);
    add_row("sllw", exu_pkg::alu_sll, 1, 0, exu_pkg::alub_imm, exu_pkg::br_none, 1, 0, 0, 31);
    add_row("jal", exu_pkg::alu_add, 0, 1, exu_pkg::alub_four, exu_pkg::br_jal, 1, 0, 0,
            64'h100);
    add_row("jalr", exu_pkg::alu_add, 0, 0, exu_pkg::alub_imm, exu_pkg::br_jalr, 1, 0, 0,
            ones - 7);
    add_row("beq taken", exu_pkg::alu_sub, 0, 0, exu_pkg::alub_rs2, exu_pkg::br_beq, 0,
            ones, ones, 64'h40);
    add_row("bne not taken", exu_pkg::alu_sub, 0, 0, exu_pkg::alub_rs2, exu_pkg::br_bne, 0,
            5, 5, 64'h40);
    add_row("blt signed", exu_pkg::alu_slt, 0, 0, exu_pkg::alub_rs2, exu_pkg::br_blt, 0,
            sign_bit, 1, ones - 63);
    add_row("blt unsigned", exu_pkg::alu_sltu, 0, 0, exu_pkg::alub_rs2, exu_pkg::br_blt, 0,
            sign_bit, 1, 64'h80);
    add_row("bge unsigned", exu_pkg::alu_sltu, 0, 0, exu_pkg::alub_rs2, exu_pkg::br_bge, 0,
            sign_bit, 1, 64'h80);
    add_row("bge signed", exu_pkg::alu_slt, 0, 0, exu_pkg::alub_rs2, exu_pkg::br_bge, 0,
            sign_bit, 1, 64'h80);
    for (int m = 0; m < 7; m++) begin
      add_row("load", exu_pkg::alu_add, 0, 0, exu_pkg::alub_imm, exu_pkg::br_none, 1, 0, 0,
              64'(m * 8));
      set_wb(exu_pkg::memop_t'(m), 1, 0, ex_nop, 0);
      // sign bits of every load width set
      rows[rows.size()-1].rdata = rows[rows.size()-1].rdata | 64'h8000_8080;
    end
    add_row("csr read", exu_pkg::alu_or, 0, 0, exu_pkg::alub_rs2, exu_pkg::br_none, 1, 0, 0, 0);
    set_wb(exu_pkg::mem_ld, 0, 1, exu_pkg::exctr_csr_write, 0);
    add_row("ebreak", exu_pkg::alu_add, 0, 0, exu_pkg::alub_rs2, exu_pkg::br_none, 1, 0, 0, 0);
    set_wb(exu_pkg::mem_ld, 0, 0, exu_pkg::exctr_ebreak, 0);
    add_row("invalid", exu_pkg::alu_xor, 0, 0, exu_pkg::alub_rs2, exu_pkg::br_none, 1, 0, 0, 0);
    set_wb(exu_pkg::mem_ld, 0, 0, ex_nop, 1);
  endtask

  task automatic apply_row(row_t r);
    i_valid = 1'b1;
    i_rs1 = r.rs1;
    i_rs2 = r.rs2;
    i_imm = r.imm;
    i_pc = r.pc;
    i_alua_src = r.asrc;
    i_alub_src = r.bsel;
    i_alu_ctr = r.ctr;
    i_word_cut = r.wc;
    i_branch = r.br;
    i_memop = r.mop;
    i_mem_to_reg = r.m2r;
    i_sel_csr = r.csel;
    i_exctr = r.ex;
    i_rdata = r.rdata;
    i_is_invalid_inst = r.inv;
  endtask

  initial begin
    i_clk = 1'b0;
    forever #(period / 2) i_clk = ~i_clk;
  end

  always @(posedge i_clk) cycle <= cycle + 1;

  // results are sampled mid-cycle away from the active edge
  always @(negedge i_clk) begin
    expect_t e;
    if (o_valid === 1'b1 && pending.size() == 0) begin
      $display("o_valid rose with no instruction in flight at %0t", $time);
      stop_failed();
    end else if (o_valid === 1'b1) begin
      e = pending.pop_front();
      check_word("latency", labels[e.idx], 64'(cycle - e.entry), 64'(exu_pkg::exu_latency));
      check_word("alu_result", labels[e.idx], o_alu_result, e.alu);
      check_word("next_pc", labels[e.idx], o_next_pc, e.npc);
      check_word("gpr_wdata", labels[e.idx], o_gpr_wdata, e.gpr);
      check_word("csr_wdata", labels[e.idx], o_csr_wdata, e.csr);
      check_bit("ebreak", labels[e.idx], o_ebreak, e.eb);
      check_bit("invalid", labels[e.idx], o_invalid, e.inv);
      checked++;
    end else begin
      check_bit("o_valid idle", "quiet", o_valid, 1'b0);
      check_bit("o_ebreak idle", "quiet", o_ebreak, 1'b0);
      check_bit("o_invalid idle", "quiet", o_invalid, 1'b0);
    end
  end

  initial begin
    expect_t e;
    void'($urandom(32'h2bd0_c455));
    i_reset = 1'b1;
    apply_row('0);
    i_valid = 1'b0;
    load_table();
    table_ready = 1'b1;
    repeat (5) @(posedge i_clk);
    @(negedge i_clk);
    i_reset = 1'b0;
    for (int k = 0; k < rows.size(); k++) begin
      apply_row(rows[k]);
      e.alu = model_alu(rows[k]);
      e.npc = model_next_pc(rows[k]);
      e.gpr = model_gpr(rows[k], e.alu);
      e.csr = (rows[k].ex == exu_pkg::exctr_csr_write) ? model_src_a(rows[k]) : 64'h0;
      e.eb = (rows[k].ex == exu_pkg::exctr_ebreak);
      e.inv = rows[k].inv;
      e.idx = k;
      // counted from the cycle the row is driven in
      e.entry = cycle;
      pending.push_back(e);
      @(negedge i_clk);
    end
    i_valid = 1'b0;
    // idle controls that must not raise the pulses
    i_exctr = exu_pkg::exctr_ebreak;
    i_is_invalid_inst = 1'b1;
    wait (checked == rows.size());
    repeat (2) @(negedge i_clk);
    if (pending.size() == 0) begin
      $display("All tests passed");
      $finish;
    end else begin
      $display("instructions still in flight at the end of the run");
      stop_failed();
    end
  end

  initial begin
    wait (table_ready);
    #((rows.size() + exu_pkg::exu_latency + 5 + 20) * period);
    $display("watchdog expired, the pipeline produced too few results");
    stop_failed();
  end

endmodule

`default_nettype wire
